/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // memory geometry
  localparam int mem_words   = 256;
  localparam int mem_index_w = 8;   // log2(mem_words)

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass_imm  // lui
  } alu_op_t;

  typedef enum logic [2:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_jump
  } branch_t;

  typedef enum logic [2:0] {
    imm_none,
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j
  } imm_fmt_t;

  typedef enum logic {
    mem_idle,
    mem_wait_access
  } mem_state_t;

  // rv32i major opcodes still decoded
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

endpackage

`default_nettype wire

/* source/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input  wire cpu_pkg::word_t     instr,
  output cpu_pkg::reg_idx_t       rs1,
  output cpu_pkg::reg_idx_t       rs2,
  output cpu_pkg::reg_idx_t       rd,
  output cpu_pkg::word_t          imm,
  output cpu_pkg::alu_op_t        alu_op,
  output logic                    use_imm,
  output cpu_pkg::branch_t        branch_kind,
  output logic                    reg_we,
  output logic                    mem_read,
  output logic                    mem_write,
  output logic                    store_byte,
  output logic                    load_byte,
  output logic                    link,
  output logic                    slt
);
  import cpu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  imm_fmt_t   fmt;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  always_comb begin
    case (opcode)
      op_imm, op_load: fmt = imm_i;
      op_store:        fmt = imm_s;
      op_branch:       fmt = imm_b;
      op_lui:          fmt = imm_u;
      op_jal:          fmt = imm_j;
      default:         fmt = imm_none;
    endcase
  end

  always_comb begin
    case (fmt)
      imm_i:   imm = {{20{instr[31]}}, instr[31:20]};
      imm_s:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      imm_b:   imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      imm_u:   imm = {instr[31:12], 12'b0};
      imm_j:   imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  always_comb begin
    // anything not matched below falls out as a no-op
    alu_op      = alu_add;
    use_imm     = 1'b0;
    branch_kind = br_none;
    reg_we      = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    store_byte  = 1'b0;
    load_byte   = 1'b0;
    link        = 1'b0;
    slt         = 1'b0;
    case (opcode)
      op_reg: begin
        reg_we = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op = alu_add;
          {7'h20, 3'b000}: alu_op = alu_sub;
          {7'h00, 3'b001}: alu_op = alu_sll;
          {7'h00, 3'b010}: begin
            alu_op = alu_sub;  // compare via flags
            slt    = 1'b1;
          end
          {7'h00, 3'b100}: alu_op = alu_xor;
          {7'h00, 3'b101}: alu_op = alu_srl;
          {7'h20, 3'b101}: alu_op = alu_sra;
          {7'h00, 3'b110}: alu_op = alu_or;
          {7'h00, 3'b111}: alu_op = alu_and;
          default:         reg_we = 1'b0;
        endcase
      end
      op_imm: begin
        reg_we  = 1'b1;
        use_imm = 1'b1;
        case (funct3)
          3'b000: alu_op = alu_add;
          3'b010: begin
            alu_op = alu_sub;
            slt    = 1'b1;
          end
          3'b100: alu_op = alu_xor;
          3'b110: alu_op = alu_or;
          3'b111: alu_op = alu_and;
          3'b001: begin
            if (funct7 == 7'h00) alu_op = alu_sll;
            else reg_we = 1'b0;
          end
          3'b101: begin
            if (funct7 == 7'h00) alu_op = alu_srl;
            else if (funct7 == 7'h20) alu_op = alu_sra;
            else reg_we = 1'b0;
          end
          default: reg_we = 1'b0;  // sltiu dropped
        endcase
      end
      op_load: begin
        use_imm = 1'b1;
        if (funct3 == 3'b000 || funct3 == 3'b010) begin
          reg_we    = 1'b1;
          mem_read  = 1'b1;
          load_byte = (funct3 == 3'b000);
        end
      end
      op_store: begin
        use_imm = 1'b1;
        if (funct3 == 3'b000 || funct3 == 3'b010) begin
          mem_write  = 1'b1;
          store_byte = (funct3 == 3'b000);
        end
      end
      op_lui: begin
        reg_we  = 1'b1;
        use_imm = 1'b1;
        alu_op  = alu_pass_imm;
      end
      op_branch: begin
        alu_op = alu_sub;  // rs1 - rs2 sets z/n/v
        case (funct3)
          3'b000:  branch_kind = br_beq;
          3'b001:  branch_kind = br_bne;
          3'b100:  branch_kind = br_blt;
          3'b101:  branch_kind = br_bge;
          default: branch_kind = br_none;
        endcase
      end
      op_jal: begin
        reg_we      = 1'b1;
        link        = 1'b1;
        branch_kind = br_jump;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  wire cpu_pkg::word_t   rs1_data,
  input  wire cpu_pkg::word_t   rs2_data,
  input  wire cpu_pkg::word_t   imm,
  input  wire                   use_imm,
  input  wire cpu_pkg::alu_op_t alu_op,
  output cpu_pkg::word_t        result,
  output logic                  z,
  output logic                  n,
  output logic                  v
);
  import cpu_pkg::*;

  word_t      b;
  logic [4:0] shamt;

  assign b     = use_imm ? imm : rs2_data;
  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      alu_add:      result = rs1_data + b;
      alu_sub:      result = rs1_data - b;
      alu_sll:      result = rs1_data << shamt;
      alu_srl:      result = rs1_data >> shamt;
      alu_sra:      result = $signed(rs1_data) >>> shamt;
      alu_and:      result = rs1_data & b;
      alu_or:       result = rs1_data | b;
      alu_xor:      result = rs1_data ^ b;
      alu_pass_imm: result = imm;
      default:      result = '0;
    endcase
  end

  assign z = (result == '0);
  assign n = result[31];

  // signed overflow, only meaningful for add/sub
  always_comb begin
    case (alu_op)
      alu_add: v = (rs1_data[31] == b[31]) && (result[31] != rs1_data[31]);
      alu_sub: v = (rs1_data[31] != b[31]) && (result[31] != rs1_data[31]);
      default: v = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input  wire                    clk,
  input  wire                    rst,
  input  wire cpu_pkg::reg_idx_t rs1,
  input  wire cpu_pkg::reg_idx_t rs2,
  input  wire cpu_pkg::reg_idx_t rd,
  input  wire                    we,
  input  wire cpu_pkg::word_t    wdata,
  output cpu_pkg::word_t         rs1_data,
  output cpu_pkg::word_t         rs2_data,
  output cpu_pkg::word_t         x8
);
  import cpu_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (we && rd != '0) begin  // x0 stays zero
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];
  assign x8       = regs[8];  // debug tap

endmodule

`default_nettype wire

/* source/pc_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_unit (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   en,
  input  wire cpu_pkg::branch_t branch_kind,
  input  wire                   z,
  input  wire                   n,
  input  wire                   v,
  input  wire cpu_pkg::word_t   imm,
  output cpu_pkg::addr_t        pc,
  output cpu_pkg::addr_t        pc_plus4
);
  import cpu_pkg::*;

  logic  taken;
  addr_t pc_next;

  assign pc_plus4 = pc + 32'd4;

  // flags come from rs1 - rs2
  always_comb begin
    case (branch_kind)
      br_beq:  taken = z;
      br_bne:  taken = !z;
      br_blt:  taken = n && !v;
      br_bge:  taken = !n && !v;
      br_jump: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign pc_next = taken ? (pc + imm) : pc_plus4;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (en) begin  // low during first cycle of a data access
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

/* source/unified_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module unified_memory (
  input  wire                 clk,
  input  wire                 rst,
  input  wire cpu_pkg::addr_t pc,
  input  wire cpu_pkg::addr_t data_addr,
  input  wire                 mem_read,
  input  wire                 mem_write,
  input  wire                 store_byte,
  input  wire cpu_pkg::word_t write_data,
  input  wire                 load_en,
  input  wire cpu_pkg::addr_t load_addr,
  input  wire cpu_pkg::word_t load_data,
  output cpu_pkg::word_t      instr,
  output cpu_pkg::word_t      read_data,
  output logic                pc_en
);
  import cpu_pkg::*;

  word_t                  mem [mem_words];
  logic [mem_index_w-1:0] pc_idx;
  logic [mem_index_w-1:0] data_idx;
  logic [mem_index_w-1:0] load_idx;
  word_t                  store_word;
  mem_state_t             state;
  mem_state_t             next_state;

  // word index = byte address / 4
  assign pc_idx   = pc[mem_index_w+1:2];
  assign data_idx = data_addr[mem_index_w+1:2];
  assign load_idx = load_addr[mem_index_w+1:2];

  assign store_word = store_byte ? {24'b0, write_data[7:0]} : write_data;

  always_ff @(negedge clk) begin
    if (rst) begin
      if (load_en) mem[load_idx] <= load_data;  // boot path
    end else if (mem_write) begin
      mem[data_idx] <= store_word;
    end
    instr     <= mem[pc_idx];
    read_data <= mem[data_idx];
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) state <= mem_idle;
    else state <= next_state;
  end

  always_comb begin
    next_state = state;
    pc_en      = 1'b1;
    case (state)
      mem_idle: begin
        if (mem_read || mem_write) begin
          pc_en      = 1'b0;  // hold pc one cycle
          next_state = mem_wait_access;
        end
      end
      mem_wait_access: next_state = mem_idle;
      default:         next_state = mem_idle;
    endcase
  end

endmodule

`default_nettype wire

/* source/cpu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 load_en,
  input  wire cpu_pkg::addr_t load_addr,
  input  wire cpu_pkg::word_t load_data,
  output cpu_pkg::addr_t      pc,
  output cpu_pkg::word_t      dbg_x8
);
  import cpu_pkg::*;

  word_t    instr;
  word_t    imm;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_result;
  word_t    read_data;
  word_t    wb_data;
  addr_t    pc_plus4;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  alu_op_t  alu_op;
  branch_t  branch_kind;
  logic     use_imm;
  logic     reg_we;
  logic     mem_read;
  logic     mem_write;
  logic     store_byte;
  logic     load_byte;
  logic     link;
  logic     slt;
  logic     z;
  logic     n;
  logic     v;
  logic     pc_en;

  instr_decoder u_decoder (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .use_imm(use_imm), .branch_kind(branch_kind),
    .reg_we(reg_we), .mem_read(mem_read), .mem_write(mem_write),
    .store_byte(store_byte), .load_byte(load_byte), .link(link), .slt(slt)
  );

  alu u_alu (
    .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .use_imm(use_imm),
    .alu_op(alu_op), .result(alu_result), .z(z), .n(n), .v(v)
  );

  register_file u_regs (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .we(reg_we),
    .wdata(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data), .x8(dbg_x8)
  );

  pc_unit u_pc (
    .clk(clk), .rst(rst), .en(pc_en), .branch_kind(branch_kind),
    .z(z), .n(n), .v(v), .imm(imm), .pc(pc), .pc_plus4(pc_plus4)
  );

  unified_memory u_mem (
    .clk(clk), .rst(rst), .pc(pc), .data_addr(alu_result),
    .mem_read(mem_read), .mem_write(mem_write), .store_byte(store_byte),
    .write_data(rs2_data), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .instr(instr), .read_data(read_data), .pc_en(pc_en)
  );

  // writeback select, first match wins
  always_comb begin
    if (link) wb_data = pc_plus4;
    else if (load_byte) wb_data = {24'b0, read_data[7:0]};
    else if (slt) wb_data = {31'b0, n && !v};
    else if (mem_read) wb_data = read_data;  // lw
    else wb_data = alu_result;
  end

endmodule

`default_nettype wire

/* verification/cpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;
  import cpu_pkg::*;

  logic  clk = 1'b0;
  logic  rst;
  logic  load_en;
  addr_t load_addr;
  word_t load_data;
  addr_t pc;
  word_t dbg_x8;

  word_t prog [$];
  word_t acc;
  word_t rng = 32'd94;

  cpu_top DUT (
    .clk(clk), .rst(rst), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .pc(pc), .dbg_x8(dbg_x8)
  );

  always #5 clk = ~clk;

  // rv32i encoders
  function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic word_t xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // negative difference without signed overflow gives 1
  function automatic word_t slt_expect(input word_t x, input word_t y);
    longint diff;
    logic   ovf;
    diff = longint'($signed(x)) - longint'($signed(y));
    ovf  = (diff > 64'sd2147483647) || (diff < -64'sd2147483648);
    return {31'b0, diff[31] && !ovf};
  endfunction

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERR %s got %08h expected %08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("ERR %s got %08h expected %08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic emit_li(input reg_idx_t rd, input word_t value);
    word_t hi;
    hi = value + 32'h800;  // addi sign-extends the low 12 bits
    prog.push_back(enc_u(hi[31:12], rd));
    prog.push_back(enc_i(value[11:0], rd, 3'b000, rd, 7'b0010011));
  endtask

  // x3 result folded into x8 by xor
  task automatic fold_result(input word_t instr, input word_t value);
    prog.push_back(instr);
    prog.push_back(enc_r(7'h00, 5'd3, 5'd8, 3'b100, 5'd8));
    acc = acc ^ value;
  endtask

  task automatic start_program();
    @(posedge clk);
    rst     <= 1'b1;
    load_en <= 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_addr("pc", pc, '0);
    check_word("dbg_x8", dbg_x8, '0);
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= addr_t'(i * 4);
      load_data <= prog[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
    rst     <= 1'b0;
    @(negedge clk);
    check_addr("pc", pc, '0);  // first cycle out of reset
    check_word("dbg_x8", dbg_x8, '0);
  endtask

  task automatic wait_halt(input addr_t exp_pc);
    addr_t prev;
    int    same;
    int    cycles;
    prev   = pc;
    same   = 0;
    cycles = 0;
    while (same < 3) begin
      @(negedge clk);
      if (pc == prev) same++;
      else same = 0;
      prev = pc;
      cycles++;
      if (cycles > 5000) begin
        $display("program did not halt within %0d cycles, pc is %08h", cycles, pc);
        abort_run();
      end
    end
    check_addr("pc", pc, exp_pc);
  endtask

  task automatic run_and_check(input word_t exp_x8);
    start_program();
    wait_halt(addr_t'((prog.size() - 1) * 4));
    check_word("dbg_x8", dbg_x8, exp_x8);
  endtask

  task automatic test_reset_nops();
    prog.delete();
    repeat (4) prog.push_back(enc_i(12'h000, 5'd0, 3'b000, 5'd0, 7'b0010011));
    prog.push_back(enc_j(21'd0, 5'd0));
    start_program();
    for (int k = 1; k <= 4; k++) begin
      @(negedge clk);
      check_addr("pc", pc, addr_t'(k * 4));
    end
    wait_halt(32'd16);
    check_word("dbg_x8", dbg_x8, '0);
  endtask

  task automatic test_alu_ops();
    word_t       a;
    word_t       b;
    word_t       r;
    word_t       immx;
    logic [11:0] imm;
    logic [4:0]  sh;
    prog.delete();
    acc = '0;
    repeat (2) begin
      a    = xorshift();
      b    = xorshift();
      r    = xorshift();
      imm  = r[11:0];
      immx = {{20{imm[11]}}, imm};
      sh   = r[16:12];
      emit_li(5'd1, a);
      emit_li(5'd2, b);
      fold_result(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), a + b);
      fold_result(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), a - b);
      fold_result(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), a & b);
      fold_result(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), a | b);
      fold_result(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), a ^ b);
      fold_result(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd3), a << b[4:0]);
      fold_result(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd3), a >> b[4:0]);
      fold_result(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), word_t'($signed(a) >>> b[4:0]));
      fold_result(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), slt_expect(a, b));
      fold_result(enc_i(imm, 5'd1, 3'b000, 5'd3, 7'b0010011), a + immx);
      fold_result(enc_i(imm, 5'd1, 3'b111, 5'd3, 7'b0010011), a & immx);
      fold_result(enc_i(imm, 5'd1, 3'b110, 5'd3, 7'b0010011), a | immx);
      fold_result(enc_i(imm, 5'd1, 3'b100, 5'd3, 7'b0010011), a ^ immx);
      fold_result(enc_i({7'h00, sh}, 5'd1, 3'b001, 5'd3, 7'b0010011), a << sh);
      fold_result(enc_i({7'h00, sh}, 5'd1, 3'b101, 5'd3, 7'b0010011), a >> sh);
      fold_result(enc_i({7'h20, sh}, 5'd1, 3'b101, 5'd3, 7'b0010011),
                  word_t'($signed(a) >>> sh));
      fold_result(enc_i(imm, 5'd1, 3'b010, 5'd3, 7'b0010011), slt_expect(a, immx));
    end
    prog.push_back(enc_j(21'd0, 5'd0));
    run_and_check(acc);
  endtask

  task automatic test_load_store();
    word_t w;
    word_t r;
    word_t exp;
    prog.delete();
    w = xorshift();
    r = xorshift();
    emit_li(5'd1, 32'h200);  // data area above the program
    emit_li(5'd2, w);
    emit_li(5'd4, r);
    prog.push_back(enc_s(12'd0, 5'd2, 5'd1, 3'b010));               // sw x2
    prog.push_back(enc_i(12'd0, 5'd1, 3'b010, 5'd3, 7'b0000011));   // lw x3
    prog.push_back(enc_i(12'd0, 5'd1, 3'b000, 5'd5, 7'b0000011));   // lb x5
    prog.push_back(enc_s(12'd4, 5'd4, 5'd1, 3'b000));               // sb x4
    prog.push_back(enc_i(12'd4, 5'd1, 3'b000, 5'd6, 7'b0000011));
    prog.push_back(enc_i(12'd4, 5'd1, 3'b010, 5'd7, 7'b0000011));   // whole word after sb
    prog.push_back(enc_r(7'h00, 5'd3, 5'd0, 3'b000, 5'd8));
    prog.push_back(enc_r(7'h00, 5'd5, 5'd8, 3'b100, 5'd8));
    prog.push_back(enc_r(7'h00, 5'd6, 5'd8, 3'b000, 5'd8));
    prog.push_back(enc_r(7'h00, 5'd7, 5'd8, 3'b100, 5'd8));
    prog.push_back(enc_j(21'd0, 5'd0));
    exp = ((w ^ {24'b0, w[7:0]}) + {24'b0, r[7:0]}) ^ {24'b0, r[7:0]};
    run_and_check(exp);
  endtask

  task automatic test_branches();
    int n;
    prog.delete();
    n = 3 + (xorshift() % 6);
    prog.push_back(enc_i(12'(n), 5'd0, 3'b000, 5'd2, 7'b0010011));
    prog.push_back(enc_i(12'd1, 5'd1, 3'b000, 5'd1, 7'b0010011));
    prog.push_back(enc_b(-13'd4, 5'd2, 5'd1, 3'b001));              // bne loop
    prog.push_back(enc_i(12'd1, 5'd3, 3'b000, 5'd3, 7'b0010011));
    prog.push_back(enc_b(-13'd4, 5'd2, 5'd3, 3'b100));              // blt loop
    prog.push_back(enc_i(12'(n + 2), 5'd0, 3'b000, 5'd4, 7'b0010011));
    prog.push_back(enc_i(12'hfff, 5'd4, 3'b000, 5'd4, 7'b0010011));
    prog.push_back(enc_b(-13'd4, 5'd2, 5'd4, 3'b101));              // bge loop, ends at n-1
    prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b000));               // taken beq skips one
    prog.push_back(enc_i(12'd100, 5'd8, 3'b000, 5'd8, 7'b0010011));
    prog.push_back(enc_r(7'h00, 5'd3, 5'd1, 3'b000, 5'd8));
    prog.push_back(enc_r(7'h00, 5'd4, 5'd8, 3'b000, 5'd8));
    prog.push_back(enc_b(13'd8, 5'd0, 5'd1, 3'b000));               // not taken
    prog.push_back(enc_i(12'd1, 5'd8, 3'b000, 5'd8, 7'b0010011));
    prog.push_back(enc_j(21'd0, 5'd0));
    run_and_check(word_t'(n + n + (n - 1) + 1));
  endtask

  task automatic test_lui_slt_jal();
    word_t up;
    prog.delete();
    up = xorshift();
    prog.push_back(enc_u(up[19:0], 5'd8));
    prog.push_back(enc_i(12'hffd, 5'd0, 3'b000, 5'd1, 7'b0010011));  // x1 = -3
    prog.push_back(enc_i(12'd4, 5'd0, 3'b000, 5'd2, 7'b0010011));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd3));          // -3 < 4
    prog.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd4));          // 4 < -3
    prog.push_back(enc_i(12'hffe, 5'd1, 3'b010, 5'd5, 7'b0010011)); // -3 < -2
    prog.push_back(enc_i(12'd4, 5'd2, 3'b010, 5'd6, 7'b0010011));   // 4 < 4
    prog.push_back(enc_r(7'h00, 5'd3, 5'd8, 3'b000, 5'd8));
    prog.push_back(enc_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd7));
    prog.push_back(enc_r(7'h00, 5'd7, 5'd8, 3'b000, 5'd8));
    prog.push_back(enc_r(7'h00, 5'd4, 5'd8, 3'b000, 5'd8));
    prog.push_back(enc_r(7'h00, 5'd6, 5'd8, 3'b000, 5'd8));
    prog.push_back(enc_j(21'd0, 5'd0));
    run_and_check({up[19:0], 12'h000} + 32'd3);
    // jal at 8 links 12 and lands on the halt at 16
    prog.delete();
    repeat (2) prog.push_back(enc_i(12'h000, 5'd0, 3'b000, 5'd0, 7'b0010011));
    prog.push_back(enc_j(21'd8, 5'd8));
    prog.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd8, 7'b0010011));
    prog.push_back(enc_j(21'd0, 5'd0));
    run_and_check(32'd12);
  endtask

  initial begin
    rst       = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    test_reset_nops();
    test_alu_ops();
    test_load_store();
    test_branches();
    test_lui_slt_jal();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
source/cpu_pkg.sv
source/instr_decoder.sv
source/alu.sv
source/register_file.sv
source/pc_unit.sv
source/unified_memory.sv
source/cpu_top.sv
verification/cpu_tb.sv
